// ==== hw/dma_defs.svh ====
// DMA controller sizing
// Channel count and the widths of address, page, count and CPU data
// Memory address is the page above the current address

`ifndef DMA_DEFS_SVH
`define DMA_DEFS_SVH

// Number of DMA channels
`define DMA_CHANNELS 4

// Current address within a page
`define DMA_ADDR_W 16

// Page register width
`define DMA_PAGE_W 4

// Transfer count, the channel runs count+1 transfers
`define DMA_COUNT_W 16

// CPU write data bus
`define DMA_DATA_W 16

// Full memory address, 20 bits
`define DMA_MEM_W (`DMA_PAGE_W + `DMA_ADDR_W)

`endif

// ==== hw/dma_reg_pkg.sv ====
// DMA register map definitions
// Field select within a channel and the mode register layout

package dma_reg_pkg;

    // ============================================================
    // Channel field select, cpu_addr bits 1:0 with dma_select
    // ============================================================
    typedef enum logic [1:0] {
        FIELD_BASE_ADDR = 2'b00,
        FIELD_COUNT     = 2'b01,
        FIELD_MODE      = 2'b10,
        FIELD_RESERVED  = 2'b11
    } dma_field_e;

    // ============================================================
    // Mode register layout
    // ============================================================
    // Bits 1:0 transfer type
    localparam int MODE_TYPE_LSB     = 0;
    // Channel enable, cleared by hardware at terminal count
    localparam int MODE_ENABLE_BIT   = 2;
    // Reload base values at terminal count
    localparam int MODE_AUTOINIT_BIT = 3;
    // Stored mode width
    localparam int MODE_W            = 4;

endpackage

// ==== hw/dma_xfer_pkg.sv ====
// DMA transfer behaviour definitions
// Transfer type of a channel and the bus engine states

package dma_xfer_pkg;

    // ============================================================
    // Transfer type, as in the mode register
    // ============================================================
    typedef enum logic [1:0] {
        // Acknowledge only, no memory access
        XFER_VERIFY   = 2'b00,
        // Device to memory
        XFER_WRITE    = 2'b01,
        // Memory to device
        XFER_READ     = 2'b10,
        // Behaves like verify
        XFER_RESERVED = 2'b11
    } dma_xfer_e;

    // ============================================================
    // Bus engine states
    // ============================================================
    typedef enum logic [1:0] {
        ENG_IDLE    = 2'b00,
        ENG_ACCESS  = 2'b01,
        ENG_RELEASE = 2'b10
    } dma_engine_state_e;

endpackage

// ==== hw/dma_reg_decode.sv ====
// DMA register write decoder
// Turns CPU chip selects and address into per-channel field strobes
// Holds the command register with the controller enable

`timescale 1ns/1ns
`include "dma_defs.svh"

module dma_reg_decode import dma_reg_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      dma_select,
    input  logic                      page_select,
    input  logic [3:0]                cpu_addr,
    input  logic [`DMA_DATA_W-1:0]    cpu_wr_data,
    input  logic                      cpu_wr,
    output logic [`DMA_CHANNELS-1:0]  base_wr,
    output logic [`DMA_CHANNELS-1:0]  count_wr,
    output logic [`DMA_CHANNELS-1:0]  mode_wr,
    output logic [`DMA_CHANNELS-1:0]  page_wr,
    output logic [`DMA_DATA_W-1:0]    wr_data,
    output logic                      ctrl_enable
);

    dma_field_e                field;
    logic [`DMA_CHANNELS-1:0]  dma_chan_sel;
    logic [`DMA_CHANNELS-1:0]  page_chan_sel;
    logic                      dma_wr;
    logic                      page_reg_wr;
    logic                      cmd_wr;

    assign field = dma_field_e'(cpu_addr[1:0]);

    // Write qualifiers per chip select
    assign dma_wr      = cpu_wr && dma_select;
    assign page_reg_wr = cpu_wr && page_select && !cpu_addr[3];
    assign cmd_wr      = cpu_wr && page_select && cpu_addr[3];

    // One-hot channel select
    // Channel registers use bits 3:2, page registers bits 1:0
    always_comb begin
        dma_chan_sel = '0;
        page_chan_sel = '0;
        dma_chan_sel[cpu_addr[3:2]] = 1'b1;
        page_chan_sel[cpu_addr[1:0]] = 1'b1;
    end

    // Field strobes, reserved field writes are dropped
    always_comb begin
        base_wr  = '0;
        count_wr = '0;
        mode_wr  = '0;
        if (dma_wr) begin
            case (field)
                FIELD_BASE_ADDR: base_wr  = dma_chan_sel;
                FIELD_COUNT:     count_wr = dma_chan_sel;
                FIELD_MODE:      mode_wr  = dma_chan_sel;
                default:         ;
            endcase
        end
    end

    assign page_wr = page_reg_wr ? page_chan_sel : '0;

    // Same data bus feeds every channel
    assign wr_data = cpu_wr_data;

    // Command register, bit 0 enables the controller
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ctrl_enable <= 1'b0;
        end else if (cmd_wr) begin
            ctrl_enable <= cpu_wr_data[0];
        end
    end

    // Chip selects are mutually exclusive on a write
    a_one_select: assert property (@(posedge clk) disable iff (reset)
        cpu_wr |-> !(dma_select && page_select));

endmodule

// ==== hw/dma_channel.sv ====
// DMA channel
// Base and current address and count, page and mode registers
// Steps address and count on each granted transfer
// At terminal count it reloads (autoinit) or disables itself

`timescale 1ns/1ns
`include "dma_defs.svh"

module dma_channel import dma_reg_pkg::*, dma_xfer_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    base_wr,
    input  logic                    count_wr,
    input  logic                    mode_wr,
    input  logic                    page_wr,
    input  logic [`DMA_DATA_W-1:0]  wr_data,
    input  logic                    request,
    input  logic                    advance,
    output logic                    pending,
    output logic [`DMA_MEM_W-1:0]   mem_addr,
    output dma_xfer_e               xfer_type,
    output logic                    last
);

    logic [`DMA_ADDR_W-1:0]   base_addr;
    logic [`DMA_ADDR_W-1:0]   cur_addr;
    logic [`DMA_COUNT_W-1:0]  base_count;
    logic [`DMA_COUNT_W-1:0]  cur_count;
    logic [`DMA_PAGE_W-1:0]   page;
    logic [MODE_W-1:0]        mode;

    // ============================================================
    // Address and count registers
    // ============================================================
    // CPU writes load base and current copy together
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            base_addr  <= '0;
            cur_addr   <= '0;
            base_count <= '0;
            cur_count  <= '0;
        end else if (base_wr) begin
            base_addr <= wr_data[`DMA_ADDR_W-1:0];
            cur_addr  <= wr_data[`DMA_ADDR_W-1:0];
        end else if (count_wr) begin
            base_count <= wr_data[`DMA_COUNT_W-1:0];
            cur_count  <= wr_data[`DMA_COUNT_W-1:0];
        end else if (advance) begin
            if (last && mode[MODE_AUTOINIT_BIT]) begin
                // Terminal count with autoinit, restart block
                cur_addr  <= base_addr;
                cur_count <= base_count;
            end else begin
                // Address wraps inside the page
                cur_addr  <= cur_addr + 1'b1;
                cur_count <= cur_count - 1'b1;
            end
        end
    end

    // ============================================================
    // Page and mode registers
    // ============================================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            page <= '0;
        end else if (page_wr) begin
            page <= wr_data[`DMA_PAGE_W-1:0];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mode <= '0;
        end else if (mode_wr) begin
            mode <= wr_data[MODE_W-1:0];
        end else if (advance && last && !mode[MODE_AUTOINIT_BIT]) begin
            // Single block done, channel stops
            mode[MODE_ENABLE_BIT] <= 1'b0;
        end
    end

    // Outputs to the engine
    assign last      = (cur_count == '0);
    assign pending   = request && mode[MODE_ENABLE_BIT];
    assign mem_addr  = {page, cur_addr};
    assign xfer_type = dma_xfer_e'(mode[MODE_TYPE_LSB +: 2]);

    // Engine only grants a channel that asked
    a_adv_pending: assert property (@(posedge clk) disable iff (reset)
        advance |-> pending);

endmodule

// ==== hw/dma_bus_engine.sv ====
// DMA bus engine
// Fixed priority grant, channel 0 highest
// Runs one bus cycle per transfer, then releases for one cycle
// Pulses advance and terminal count when the transfer completes

`timescale 1ns/1ns
`include "dma_defs.svh"

module dma_bus_engine import dma_xfer_pkg::*; (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 ctrl_enable,
    input  logic [`DMA_CHANNELS-1:0]             pending,
    input  logic [`DMA_CHANNELS*`DMA_MEM_W-1:0]  mem_addr_flat,
    input  logic [`DMA_CHANNELS*2-1:0]           xfer_type_flat,
    input  logic [`DMA_CHANNELS-1:0]             last,
    input  logic                                 m_ack,
    output logic [`DMA_CHANNELS-1:0]             advance,
    output logic [`DMA_CHANNELS-1:0]             dma_acknowledge,
    output logic                                 terminal_count,
    output logic [`DMA_MEM_W-1:0]                m_addr,
    output logic                                 m_access,
    output logic                                 m_wr_en
);

    localparam int N     = `DMA_CHANNELS;
    localparam int IDX_W = $clog2(N);

    dma_engine_state_e     state;
    logic [IDX_W-1:0]      win_idx;
    logic                  win_valid;
    logic [IDX_W-1:0]      grant;
    logic [N-1:0]          grant_onehot;
    logic [`DMA_MEM_W-1:0] addr_q;
    dma_xfer_e             type_q;
    logic                  in_access;
    logic                  mem_cycle;
    logic                  done;

    // Lowest pending index wins, scan from the top down
    always_comb begin
        win_valid = 1'b0;
        win_idx = '0;
        for (int i = N - 1; i >= 0; i--) begin
            if (pending[i]) begin
                win_valid = 1'b1;
                win_idx = IDX_W'(i);
            end
        end
    end

    // ============================================================
    // State machine
    // ============================================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state  <= ENG_IDLE;
            grant  <= '0;
            addr_q <= '0;
            type_q <= XFER_VERIFY;
        end else begin
            case (state)
                ENG_IDLE: begin
                    if (ctrl_enable && win_valid) begin
                        state  <= ENG_ACCESS;
                        grant  <= win_idx;
                        addr_q <= mem_addr_flat[win_idx*`DMA_MEM_W +: `DMA_MEM_W];
                        type_q <= dma_xfer_e'(xfer_type_flat[win_idx*2 +: 2]);
                    end
                end
                ENG_ACCESS: begin
                    if (done) begin
                        state <= ENG_RELEASE;
                    end
                end
                default: state <= ENG_IDLE;
            endcase
        end
    end

    // Verify and reserved types skip the memory
    assign mem_cycle = (type_q == XFER_WRITE) || (type_q == XFER_READ);
    assign in_access = (state == ENG_ACCESS);
    // Verify completes after one cycle, memory waits for m_ack
    assign done      = in_access && (!mem_cycle || m_ack);

    assign grant_onehot = {{(N-1){1'b0}}, 1'b1} << grant;

    // Outputs, all low outside ENG_ACCESS
    assign dma_acknowledge = in_access ? grant_onehot : '0;
    assign m_access        = in_access && mem_cycle;
    assign m_wr_en         = m_access && (type_q == XFER_WRITE);
    assign m_addr          = addr_q;
    assign advance         = done ? grant_onehot : '0;
    assign terminal_count  = done && last[grant];

    // ============================================================
    // Bus checks
    // ============================================================
    a_ack_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(dma_acknowledge));

    a_access_ack: assert property (@(posedge clk) disable iff (reset)
        m_access |-> (dma_acknowledge != '0));

    // Request held stable until the bus answers
    a_addr_hold: assert property (@(posedge clk) disable iff (reset)
        (m_access && !m_ack) |=> (m_access && $stable(m_addr) && $stable(m_wr_en)));

endmodule

// ==== hw/dma_unit.sv ====
// Four channel fly-by DMA controller
// CPU register decoder, one block per channel and the bus engine
// Devices move the data themselves, the controller drives address only

`timescale 1ns/1ns
`include "dma_defs.svh"

module dma_unit (
    input  logic                      clk,
    input  logic                      reset,
    // CPU write port
    input  logic                      dma_select,
    input  logic                      page_select,
    input  logic [3:0]                cpu_addr,
    input  logic [`DMA_DATA_W-1:0]    cpu_wr_data,
    input  logic                      cpu_wr,
    // Devices
    input  logic [`DMA_CHANNELS-1:0]  dma_request,
    output logic [`DMA_CHANNELS-1:0]  dma_acknowledge,
    output logic                      terminal_count,
    // Memory bus
    output logic [`DMA_MEM_W-1:0]     m_addr,
    output logic                      m_access,
    output logic                      m_wr_en,
    input  logic                      m_ack
);

    localparam int N = `DMA_CHANNELS;

    logic [N-1:0]              base_wr;
    logic [N-1:0]              count_wr;
    logic [N-1:0]              mode_wr;
    logic [N-1:0]              page_wr;
    logic [`DMA_DATA_W-1:0]    wr_data;
    logic                      ctrl_enable;
    logic [N-1:0]              pending;
    logic [N-1:0]              last;
    logic [N-1:0]              advance;
    // Per-channel address and type, packed side by side
    logic [N*`DMA_MEM_W-1:0]   mem_addr_flat;
    logic [N*2-1:0]            xfer_type_flat;

    dma_reg_decode u_decode (
        .clk         (clk),
        .reset       (reset),
        .dma_select  (dma_select),
        .page_select (page_select),
        .cpu_addr    (cpu_addr),
        .cpu_wr_data (cpu_wr_data),
        .cpu_wr      (cpu_wr),
        .base_wr     (base_wr),
        .count_wr    (count_wr),
        .mode_wr     (mode_wr),
        .page_wr     (page_wr),
        .wr_data     (wr_data),
        .ctrl_enable (ctrl_enable)
    );

    // ============================================================
    // Channels
    // ============================================================
    for (genvar ch = 0; ch < N; ch++) begin : g_chan
        dma_channel u_chan (
            .clk       (clk),
            .reset     (reset),
            .base_wr   (base_wr[ch]),
            .count_wr  (count_wr[ch]),
            .mode_wr   (mode_wr[ch]),
            .page_wr   (page_wr[ch]),
            .wr_data   (wr_data),
            .request   (dma_request[ch]),
            .advance   (advance[ch]),
            .pending   (pending[ch]),
            .mem_addr  (mem_addr_flat[ch*`DMA_MEM_W +: `DMA_MEM_W]),
            .xfer_type (xfer_type_flat[ch*2 +: 2]),
            .last      (last[ch])
        );
    end

    dma_bus_engine u_engine (
        .clk             (clk),
        .reset           (reset),
        .ctrl_enable     (ctrl_enable),
        .pending         (pending),
        .mem_addr_flat   (mem_addr_flat),
        .xfer_type_flat  (xfer_type_flat),
        .last            (last),
        .m_ack           (m_ack),
        .advance         (advance),
        .dma_acknowledge (dma_acknowledge),
        .terminal_count  (terminal_count),
        .m_addr          (m_addr),
        .m_access        (m_access),
        .m_wr_en         (m_wr_en)
    );

endmodule

// ==== verif/dma_unit_tb.sv ====
// Testbench for the four channel fly-by DMA controller
// Programs channels over the CPU port, models devices and a memory bus
// with random latency, and checks every completed transfer against a
// reference address model, priority order and terminal count

`timescale 1ns/1ns
`include "dma_defs.svh"

module dma_unit_tb import dma_reg_pkg::*, dma_xfer_pkg::*; ();

    localparam int N = `DMA_CHANNELS;
    // Transfers summed over the six tests 10 + 5 + 8 + 12 + 8 + 3
    localparam int TOTAL_XFERS = 46;
    localparam int CYCLE_LIMIT = 20 * TOTAL_XFERS + 2000;

    logic                     clk;
    logic                     reset;
    logic                     dma_select;
    logic                     page_select;
    logic [3:0]               cpu_addr;
    logic [`DMA_DATA_W-1:0]   cpu_wr_data;
    logic                     cpu_wr;
    logic [N-1:0]             dma_request = '0;
    logic [N-1:0]             dma_acknowledge;
    logic                     terminal_count;
    logic [`DMA_MEM_W-1:0]    m_addr;
    logic                     m_access;
    logic                     m_wr_en;
    logic                     m_ack = 1'b0;

    // Channel setup as programmed for the reference model
    logic [`DMA_PAGE_W-1:0]   page_cfg [N];
    logic [`DMA_ADDR_W-1:0]   base_cfg [N];
    int                       count_cfg [N];
    bit                       auto_cfg [N];
    dma_xfer_e                type_cfg [N];
    // Completed transfers and terminal counts seen per channel
    int                       xfer_k [N];
    int                       tc_seen [N];
    // Device holds its request while fewer completions than this
    int                       req_target [N];
    int                       grant_log [$];
    bit                       ctrl_on;
    int                       value_errs;
    int                       other_errs;
    int                       cycles;
    int                       wait_left;

    dma_unit dma_unit_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Watchdog
    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Checks failed: %0d value, %0d other", value_errs, other_errs);
            $display("Errors found");
            $finish;
        end
    end

    // ============================================================
    // Device and memory bus models
    // ============================================================
    always @(negedge clk) begin
        for (int i = 0; i < N; i++) begin
            dma_request[i] = (xfer_k[i] < req_target[i]);
        end
    end

    // Answer each access after 0 to 5 cycles
    always @(negedge clk) begin
        m_ack = 1'b0;
        if (!m_access) begin
            wait_left = -1;
        end else begin
            if (wait_left < 0)
                wait_left = int'($urandom % 6);
            if (wait_left == 0)
                m_ack = 1'b1;
            else
                wait_left--;
        end
    end

    // Expected memory address of transfer k with wrap inside the page
    function automatic logic [`DMA_MEM_W-1:0] expected_addr(
        input logic [`DMA_PAGE_W-1:0] page, input logic [`DMA_ADDR_W-1:0] base,
        input int count, input bit autoinit, input int k);
        int                      step;
        logic [`DMA_ADDR_W-1:0]  offset;
        step = autoinit ? (k % (count + 1)) : k;
        offset = base + `DMA_ADDR_W'(step);
        return {page, offset};
    endfunction

    // ============================================================
    // Checker for each completed transfer
    // ============================================================
    always @(posedge clk) begin
        int                     ch;
        int                     k;
        bit                     is_last;
        logic [`DMA_MEM_W-1:0]  exp;
        ch = 0;
        if (!reset && dma_acknowledge != '0 && (!m_access || m_ack)) begin
            for (int i = 0; i < N; i++)
                if (dma_acknowledge[i])
                    ch = i;
            k = xfer_k[ch];
            assert (ctrl_on) else begin
                other_errs++;
                $display("Channel %0d acknowledged while the controller is off", ch);
            end
            assert (auto_cfg[ch] || k <= count_cfg[ch]) else begin
                other_errs++;
                $display("Channel %0d acknowledged after its terminal count", ch);
            end
            if (type_cfg[ch] == XFER_VERIFY) begin
                assert (!m_access) else begin
                    value_errs++;
                    $display("[FAIL] %0t: ch%0d verify made a memory access", $time, ch);
                end
            end else begin
                exp = expected_addr(page_cfg[ch], base_cfg[ch], count_cfg[ch],
                                    auto_cfg[ch], k);
                assert (m_access && m_wr_en == (type_cfg[ch] == XFER_WRITE)) else begin
                    value_errs++;
                    $display("[FAIL] %0t: ch%0d access %0b wr_en %0b", $time, ch,
                             m_access, m_wr_en);
                end
                assert (m_addr == exp) else begin
                    value_errs++;
                    $display("[FAIL] %0t: ch%0d xfer %0d addr %h expected %h", $time,
                             ch, k, m_addr, exp);
                end
            end
            is_last = auto_cfg[ch] ? (k % (count_cfg[ch] + 1) == count_cfg[ch])
                                   : (k == count_cfg[ch]);
            assert (terminal_count == is_last) else begin
                value_errs++;
                $display("[FAIL] %0t: ch%0d xfer %0d terminal_count %0b expected %0b",
                         $time, ch, k, terminal_count, is_last);
            end
            if (terminal_count)
                tc_seen[ch]++;
            grant_log.push_back(ch);
            xfer_k[ch] = k + 1;
        end else if (!reset) begin
            assert (!terminal_count) else begin
                value_errs++;
                $display("[FAIL] %0t: terminal_count outside a transfer", $time);
            end
        end
    end

    // ============================================================
    // CPU side tasks
    // ============================================================
    task automatic cpu_write(input logic dsel, input logic psel, input logic [3:0] addr,
                             input logic [`DMA_DATA_W-1:0] data);
        @(negedge clk);
        dma_select  = dsel;
        page_select = psel;
        cpu_addr    = addr;
        cpu_wr_data = data;
        cpu_wr      = 1'b1;
        @(negedge clk);
        cpu_wr      = 1'b0;
        dma_select  = 1'b0;
        page_select = 1'b0;
    endtask

    task automatic set_enable(input bit en);
        cpu_write(1'b0, 1'b1, 4'b1000, `DMA_DATA_W'(en));
        ctrl_on = en;
    endtask

    task automatic program_channel(input int ch, input logic [`DMA_PAGE_W-1:0] page,
        input logic [`DMA_ADDR_W-1:0] base, input int count, input dma_xfer_e xtype,
        input bit autoinit);
        logic [`DMA_DATA_W-1:0] mode_val;
        page_cfg[ch]  = page;
        base_cfg[ch]  = base;
        count_cfg[ch] = count;
        auto_cfg[ch]  = autoinit;
        type_cfg[ch]  = xtype;
        // Device stays quiet until the test sets its target
        req_target[ch] = 0;
        xfer_k[ch]    = 0;
        tc_seen[ch]   = 0;
        mode_val = '0;
        mode_val[MODE_TYPE_LSB +: 2]  = xtype;
        mode_val[MODE_ENABLE_BIT]     = 1'b1;
        mode_val[MODE_AUTOINIT_BIT]   = autoinit;
        cpu_write(1'b1, 1'b0, 4'(ch * 4 + int'(FIELD_BASE_ADDR)), base);
        cpu_write(1'b1, 1'b0, 4'(ch * 4 + int'(FIELD_COUNT)), `DMA_DATA_W'(count));
        cpu_write(1'b0, 1'b1, 4'(ch), `DMA_DATA_W'(page));
        // Mode goes last since it enables the channel
        cpu_write(1'b1, 1'b0, 4'(ch * 4 + int'(FIELD_MODE)), mode_val);
    endtask

    task automatic wait_xfers(input int ch, input int n);
        while (xfer_k[ch] < n)
            @(posedge clk);
    endtask

    task automatic check_totals(input int ch, input int n, input int tcs);
        assert (xfer_k[ch] == n && tc_seen[ch] == tcs) else begin
            value_errs++;
            $display("[FAIL] %0t: ch%0d %0d transfers %0d tc, expected %0d and %0d",
                     $time, ch, xfer_k[ch], tc_seen[ch], n, tcs);
        end
    endtask

    // ============================================================
    // Test sequence
    // ============================================================
    initial begin
        int exp_seq [$];
        void'($urandom(32'h181cee23));
        dma_select = 1'b0;
        page_select = 1'b0;
        cpu_addr = '0;
        cpu_wr_data = '0;
        cpu_wr = 1'b0;
        reset = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        set_enable(1'b1);

        // Write block that crosses 16'hFFFF inside page A
        program_channel(0, 4'hA, 16'hFFFF - 16'($urandom % 6), 9, XFER_WRITE, 1'b0);
        req_target[0] = 10;
        wait_xfers(0, 10);
        check_totals(0, 10, 1);

        // Channel stops at terminal count while its request stays high
        program_channel(1, 4'h3, 16'h1200, 4, XFER_WRITE, 1'b0);
        req_target[1] = 9;
        wait_xfers(1, 5);
        repeat (30) @(posedge clk);
        check_totals(1, 5, 1);
        req_target[1] = 0;

        // Two autoinit blocks from the same base
        program_channel(1, 4'h5, 16'h00F0, 3, XFER_WRITE, 1'b1);
        req_target[1] = 8;
        wait_xfers(1, 8);
        check_totals(1, 8, 2);

        // Fixed priority with four channels on separate pages
        program_channel(0, 4'h1, 16'h0100, 2, XFER_WRITE, 1'b0);
        program_channel(1, 4'h2, 16'h0200, 3, XFER_WRITE, 1'b0);
        program_channel(2, 4'h4, 16'h0300, 1, XFER_WRITE, 1'b0);
        program_channel(3, 4'h8, 16'h0400, 2, XFER_WRITE, 1'b0);
        grant_log.delete();
        for (int c = 0; c < N; c++) begin
            req_target[c] = count_cfg[c] + 1;
            for (int j = 0; j <= count_cfg[c]; j++)
                exp_seq.push_back(c);
        end
        for (int c = 0; c < N; c++)
            wait_xfers(c, count_cfg[c] + 1);
        assert (grant_log == exp_seq) else begin
            value_errs++;
            $display("[FAIL] %0t: grant order %p expected %p", $time, grant_log, exp_seq);
        end

        // Verify and read share the same count behaviour
        program_channel(2, 4'h6, 16'h4000, 3, XFER_VERIFY, 1'b0);
        program_channel(3, 4'h7, 16'h5000, 3, XFER_READ, 1'b0);
        req_target[2] = 4;
        req_target[3] = 4;
        wait_xfers(2, 4);
        wait_xfers(3, 4);
        check_totals(2, 4, 1);
        check_totals(3, 4, 1);

        // Controller off holds every request
        set_enable(1'b0);
        program_channel(0, 4'h9, 16'h0800, 2, XFER_WRITE, 1'b0);
        req_target[0] = 3;
        repeat (50) @(posedge clk);
        check_totals(0, 0, 0);
        set_enable(1'b1);
        wait_xfers(0, 3);
        check_totals(0, 3, 1);

        repeat (3) @(posedge clk);
        $display("Checks failed: %0d value, %0d other", value_errs, other_errs);
        if (value_errs + other_errs == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+hw
hw/dma_reg_pkg.sv
hw/dma_xfer_pkg.sv
hw/dma_reg_decode.sv
hw/dma_channel.sv
hw/dma_bus_engine.sv
hw/dma_unit.sv
verif/dma_unit_tb.sv

// ==== Makefile ====
# Verilator build and run for the DMA controller testbench

VERILATOR ?= verilator
TOP       ?= dma_unit_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= No errors
FAIL_MSG  ?= Errors found

SOURCES := $(wildcard hw/*.sv hw/*.svh verif/*.sv)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not complete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
